//--- source/nvic_defs.svh
//--------------------------------------------------------------------------
// NVIC priority core shared definitions
// widths, irq count and the architectural exception numbers
//--------------------------------------------------------------------------

`ifndef NVIC_DEFS_SVH
`define NVIC_DEFS_SVH

// number of irq lines, fixed by the architecture of this core
`define NVIC_NUM_IRQ   32

// priority level width, four levels with 0 the highest
`define NVIC_LVL_W     2

// exception number width as held in ipsr
`define NVIC_VEC_W     6

// one-hot active list covers nmi, hardfault, svc, pendsv, systick, irqs
`define NVIC_ACTV_W    37

// system exception numbers
`define NVIC_VEC_NMI   6'd2
`define NVIC_VEC_HDF   6'd3
`define NVIC_VEC_SVC   6'd11
`define NVIC_VEC_PSV   6'd14
`define NVIC_VEC_TCK   6'd15

// irq n has exception number base plus n
`define NVIC_VEC_IRQ0  6'd16

`endif

//--- source/nvic_pkg.sv
//--------------------------------------------------------------------------
// NVIC priority core types
// vector typedefs for the widths that carry a meaning
//--------------------------------------------------------------------------

`include "nvic_defs.svh"

package nvic_pkg;

   // exception number, as held in ipsr
   typedef logic [`NVIC_VEC_W-1:0] vec_num_t;

   // priority level
   // a lower value is a higher priority
   typedef logic [`NVIC_LVL_W-1:0] prio_lvl_t;

   // one bit per irq line
   typedef logic [`NVIC_NUM_IRQ-1:0] irq_mask_t;

   // packed irq levels
   // irq n sits in bits 2n+1 down to 2n
   typedef logic [`NVIC_NUM_IRQ*`NVIC_LVL_W-1:0] irq_lvl_t;

   // one-hot active list
   // bit 0 nmi then hardfault, svcall, pendsv, systick
   // bits 5 upwards are irq0 to irq31
   typedef logic [`NVIC_ACTV_W-1:0] actv_bit_t;

   // tournament candidate
   // top bit is enabled and pending, then level, then exception number
   typedef logic [`NVIC_LVL_W+`NVIC_VEC_W:0] cand_t;

endpackage

//--- source/nvic_active_decode.sv
//--------------------------------------------------------------------------
// NVIC active exception decode
// turns the ipsr exception number into a one-hot active list and
// works out the priority level of the active prioritisable exception
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "nvic_defs.svh"

module nvic_active_decode (
   input  nvic_pkg::vec_num_t  ipsr_i,
   input  logic                nmi_active_i,
   input  logic                hdf_active_i,
   input  nvic_pkg::prio_lvl_t svc_lvl_i,
   input  nvic_pkg::prio_lvl_t psv_lvl_i,
   input  nvic_pkg::prio_lvl_t tck_lvl_i,
   input  nvic_pkg::irq_lvl_t  irq_lvl_i,
   output nvic_pkg::actv_bit_t actv_bit_o,
   output logic                int_actv_o,
   output nvic_pkg::prio_lvl_t int_actv_lvl_o
);

   logic                svc_actv;
   logic                psv_actv;
   logic                tck_actv;
   nvic_pkg::irq_mask_t irq_actv_bit;
   logic                irq_actv;
   nvic_pkg::prio_lvl_t irq_actv_lvl;

   //-----------------------------------------------------------------------
   // system exception decode
   //-----------------------------------------------------------------------

   // nmi and hardfault come decoded from the core already
   assign svc_actv = (ipsr_i == `NVIC_VEC_SVC);
   assign psv_actv = (ipsr_i == `NVIC_VEC_PSV);
   assign tck_actv = (ipsr_i == `NVIC_VEC_TCK);

   //-----------------------------------------------------------------------
   // irq decode
   //-----------------------------------------------------------------------

   // one comparator per irq against its exception number
   for (genvar n = 0; n < `NVIC_NUM_IRQ; n++)
   begin : g_irq_dec
      assign irq_actv_bit[n] = (ipsr_i == nvic_pkg::vec_num_t'(`NVIC_VEC_IRQ0 + n));
   end

   assign irq_actv = |irq_actv_bit;

   // mask each irq level with its active bit and or them together
   // at most one irq is active so the or acts as a mux
   always_comb
   begin
      irq_actv_lvl = '0;
      for (int n = 0; n < `NVIC_NUM_IRQ; n++)
      begin
         irq_actv_lvl = irq_actv_lvl |
                        ({`NVIC_LVL_W{irq_actv_bit[n]}} &
                         irq_lvl_i[n*`NVIC_LVL_W +: `NVIC_LVL_W]);
      end
   end

   //-----------------------------------------------------------------------
   // active level and list
   //-----------------------------------------------------------------------

   // only svc, pendsv, systick and irqs have a programmable level
   assign int_actv_o = irq_actv | tck_actv | psv_actv | svc_actv;

   // zero when nothing prioritisable is active
   assign int_actv_lvl_o = irq_actv_lvl                        |
                           ({`NVIC_LVL_W{tck_actv}} & tck_lvl_i) |
                           ({`NVIC_LVL_W{psv_actv}} & psv_lvl_i) |
                           ({`NVIC_LVL_W{svc_actv}} & svc_lvl_i);

   // thread mode and unimplemented numbers leave the list empty
   assign actv_bit_o = {irq_actv_bit,
                        tck_actv,
                        psv_actv,
                        svc_actv,
                        hdf_active_i,
                        nmi_active_i};

endmodule

//--- source/nvic_pend_tree.sv
//--------------------------------------------------------------------------
// NVIC pending tournament
// picks the highest priority enabled and pending exception among the
// irqs, svcall, pendsv and systick, lowest number winning on a tie
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "nvic_defs.svh"

module nvic_pend_tree (
   input  logic                pend_svc_i,
   input  logic                pend_psv_i,
   input  logic                pend_tck_i,
   input  nvic_pkg::irq_mask_t pend_irq_i,
   input  nvic_pkg::irq_mask_t irq_en_i,
   input  nvic_pkg::irq_lvl_t  irq_lvl_i,
   input  nvic_pkg::prio_lvl_t svc_lvl_i,
   input  nvic_pkg::prio_lvl_t psv_lvl_i,
   input  nvic_pkg::prio_lvl_t tck_lvl_i,
   input  logic                dbg_maskints_i,
   output logic                pend_valid_o,
   output nvic_pkg::prio_lvl_t pend_lvl_o,
   output nvic_pkg::vec_num_t  pend_num_o
);

   nvic_pkg::irq_mask_t en_pend_irq;
   // heap of tournament nodes, leaves at NUM_IRQ upwards and root at 1
   nvic_pkg::cand_t     node [1:2*`NVIC_NUM_IRQ-1];
   nvic_pkg::cand_t     cand_irq;
   nvic_pkg::cand_t     cand_svc;
   nvic_pkg::cand_t     cand_psv;
   nvic_pkg::cand_t     cand_tck;
   nvic_pkg::cand_t     semi_sys;
   nvic_pkg::cand_t     semi_mix;
   nvic_pkg::cand_t     final_c;

   //-----------------------------------------------------------------------
   // match between two candidates
   //-----------------------------------------------------------------------

   // first must carry the lower exception number so it wins ties
   // second only wins when strictly higher priority or first is idle
   function automatic nvic_pkg::cand_t winner(input nvic_pkg::cand_t first,
                                              input nvic_pkg::cand_t second);
      nvic_pkg::prio_lvl_t lvl_1st;
      nvic_pkg::prio_lvl_t lvl_2nd;
      logic                enp_1st;
      logic                enp_2nd;
      logic                sel_2nd;

      lvl_1st = first[`NVIC_VEC_W +: `NVIC_LVL_W];
      lvl_2nd = second[`NVIC_VEC_W +: `NVIC_LVL_W];
      enp_1st = first[`NVIC_VEC_W+`NVIC_LVL_W];
      enp_2nd = second[`NVIC_VEC_W+`NVIC_LVL_W];
      sel_2nd = (enp_2nd & (lvl_2nd < lvl_1st)) | ~enp_1st;
      return sel_2nd ? second : first;
   endfunction

   //-----------------------------------------------------------------------
   // irq tournament 32 to 1
   //-----------------------------------------------------------------------

   assign en_pend_irq = pend_irq_i & irq_en_i;

   // leaves in irq order so left children always hold lower numbers
   for (genvar n = 0; n < `NVIC_NUM_IRQ; n++)
   begin : g_leaf
      assign node[`NVIC_NUM_IRQ+n] = {en_pend_irq[n],
                                      irq_lvl_i[n*`NVIC_LVL_W +: `NVIC_LVL_W],
                                      nvic_pkg::vec_num_t'(`NVIC_VEC_IRQ0 + n)};
   end

   // level 0 halves 32 to 16, level 4 gives the single irq winner
   for (genvar l = 0; l < $clog2(`NVIC_NUM_IRQ); l++)
   begin : g_level
      for (genvar i = 0; i < (`NVIC_NUM_IRQ >> (l + 1)); i++)
      begin : g_match
         localparam int idx = (`NVIC_NUM_IRQ >> (l + 1)) + i;
         assign node[idx] = winner(node[2*idx], node[2*idx+1]);
      end
   end

   //-----------------------------------------------------------------------
   // system handlers and debug masking
   //-----------------------------------------------------------------------

   // svcall is never masked or an svc under debug would deadlock
   assign cand_svc = {pend_svc_i, svc_lvl_i, `NVIC_VEC_SVC};
   assign cand_psv = {pend_psv_i & ~dbg_maskints_i, psv_lvl_i, `NVIC_VEC_PSV};
   assign cand_tck = {pend_tck_i & ~dbg_maskints_i, tck_lvl_i, `NVIC_VEC_TCK};

   // masking applied once on the irq winner instead of per leaf
   assign cand_irq = {node[1][`NVIC_VEC_W+`NVIC_LVL_W] & ~dbg_maskints_i,
                      node[1][`NVIC_VEC_W+`NVIC_LVL_W-1:0]};

   //-----------------------------------------------------------------------
   // final rounds
   //-----------------------------------------------------------------------

   assign semi_sys = winner(cand_svc, cand_psv);
   assign semi_mix = winner(cand_tck, cand_irq);
   assign final_c  = winner(semi_sys, semi_mix);

   assign pend_valid_o = final_c[`NVIC_VEC_W+`NVIC_LVL_W];
   assign pend_lvl_o   = final_c[`NVIC_VEC_W +: `NVIC_LVL_W];

   // number forced to zero when nothing enabled is pending
   assign pend_num_o = final_c[`NVIC_VEC_W-1:0] & {`NVIC_VEC_W{pend_valid_o}};

endmodule

//--- source/nvic_preempt.sv
//--------------------------------------------------------------------------
// NVIC preemption decision
// merges nmi, hardfault and the tournament winner against the active
// level and primask, and registers the core-facing results on sclk
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "nvic_defs.svh"

module nvic_preempt (
   input  logic                sclk,
   input  logic                hreset_n,
   input  nvic_pkg::actv_bit_t actv_bit_i,
   input  logic                int_actv_i,
   input  nvic_pkg::prio_lvl_t int_actv_lvl_i,
   input  logic                pend_valid_i,
   input  nvic_pkg::prio_lvl_t pend_lvl_i,
   input  nvic_pkg::vec_num_t  pend_num_i,
   input  nvic_pkg::prio_lvl_t svc_lvl_i,
   input  logic                pend_nmi_i,
   input  logic                pend_hdf_i,
   input  logic                primask_i,
   output logic                int_pend_o,
   output logic                wfi_advance_o,
   output logic                svc_escalate_o,
   output nvic_pkg::vec_num_t  int_pend_num_o,
   output nvic_pkg::actv_bit_t actv_bit_o
);

   logic               nmi_actv;
   logic               n_or_h_actv;
   logic               nmi_preempt;
   logic               hdf_preempt;
   logic               lvl_ok;
   logic               tree_preempt;
   logic               int_pend;
   logic               wfi_advance;
   logic               svc_escalate;
   nvic_pkg::vec_num_t int_pend_num;

   //-----------------------------------------------------------------------
   // preemption rules
   //-----------------------------------------------------------------------

   // bits 0 and 1 of the active list are nmi and hardfault
   assign nmi_actv    = actv_bit_i[0];
   assign n_or_h_actv = actv_bit_i[0] | actv_bit_i[1];

   // nmi preempts anything but itself
   assign nmi_preempt = pend_nmi_i & ~nmi_actv;
   // hardfault preempts unless nmi or hardfault already running
   assign hdf_preempt = pend_hdf_i & ~n_or_h_actv;

   // winner must be strictly higher priority than the active level
   assign lvl_ok       = (pend_lvl_i < int_actv_lvl_i) | ~int_actv_i;
   assign tree_preempt = pend_valid_i & lvl_ok & ~n_or_h_actv;

   // a wfi still retires on an exception held off only by primask
   assign wfi_advance = tree_preempt | nmi_preempt | hdf_preempt;
   assign int_pend    = (tree_preempt & ~primask_i) | nmi_preempt | hdf_preempt;

   // nmi over hardfault over the tournament winner
   always_comb
   begin
      if (pend_nmi_i)
         int_pend_num = `NVIC_VEC_NMI;
      else if (pend_hdf_i)
         int_pend_num = `NVIC_VEC_HDF;
      else
         int_pend_num = pend_num_i;
   end

   // svc at or below the active priority cannot be taken
   assign svc_escalate = int_actv_i & (svc_lvl_i >= int_actv_lvl_i);

   //-----------------------------------------------------------------------
   // output registers
   //-----------------------------------------------------------------------

   always_ff @(posedge sclk or negedge hreset_n)
   begin
      if (!hreset_n)
      begin
         int_pend_o     <= 1'b0;
         wfi_advance_o  <= 1'b0;
         svc_escalate_o <= 1'b0;
         int_pend_num_o <= '0;
         actv_bit_o     <= '0;
      end
      else
      begin
         int_pend_o     <= int_pend;
         wfi_advance_o  <= wfi_advance;
         svc_escalate_o <= svc_escalate;
         int_pend_num_o <= int_pend_num;
         actv_bit_o     <= actv_bit_i;
      end
   end

endmodule

//--- source/nvic_prio_top.sv
//--------------------------------------------------------------------------
// NVIC exception prioritisation core
// active decode and pending tournament side by side, feeding the
// registered preemption stage
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "nvic_defs.svh"

module nvic_prio_top (
   input  logic                sclk,
   input  logic                hreset_n,
   // core state
   input  nvic_pkg::vec_num_t  ipsr_i,
   input  logic                nmi_active_i,
   input  logic                hdf_active_i,
   input  logic                primask_i,
   input  logic                dbg_maskints_i,
   // pend bits
   input  logic                pend_nmi_i,
   input  logic                pend_hdf_i,
   input  logic                pend_svc_i,
   input  logic                pend_psv_i,
   input  logic                pend_tck_i,
   input  nvic_pkg::irq_mask_t pend_irq_i,
   input  nvic_pkg::irq_mask_t irq_en_i,
   // priority levels
   input  nvic_pkg::prio_lvl_t svc_lvl_i,
   input  nvic_pkg::prio_lvl_t psv_lvl_i,
   input  nvic_pkg::prio_lvl_t tck_lvl_i,
   input  nvic_pkg::irq_lvl_t  irq_lvl_i,
   // registered results to the core
   output logic                int_pend_o,
   output nvic_pkg::vec_num_t  int_pend_num_o,
   output logic                wfi_advance_o,
   output logic                svc_escalate_o,
   output nvic_pkg::actv_bit_t actv_bit_o
);

   nvic_pkg::actv_bit_t actv_bit;
   logic                int_actv;
   nvic_pkg::prio_lvl_t int_actv_lvl;
   logic                pend_valid;
   nvic_pkg::prio_lvl_t pend_lvl;
   nvic_pkg::vec_num_t  pend_num;

   //-----------------------------------------------------------------------
   // combinational front end
   //-----------------------------------------------------------------------

   nvic_active_decode u_active (
      .ipsr_i         (ipsr_i),
      .nmi_active_i   (nmi_active_i),
      .hdf_active_i   (hdf_active_i),
      .svc_lvl_i      (svc_lvl_i),
      .psv_lvl_i      (psv_lvl_i),
      .tck_lvl_i      (tck_lvl_i),
      .irq_lvl_i      (irq_lvl_i),
      .actv_bit_o     (actv_bit),
      .int_actv_o     (int_actv),
      .int_actv_lvl_o (int_actv_lvl)
   );

   nvic_pend_tree u_pend (
      .pend_svc_i     (pend_svc_i),
      .pend_psv_i     (pend_psv_i),
      .pend_tck_i     (pend_tck_i),
      .pend_irq_i     (pend_irq_i),
      .irq_en_i       (irq_en_i),
      .irq_lvl_i      (irq_lvl_i),
      .svc_lvl_i      (svc_lvl_i),
      .psv_lvl_i      (psv_lvl_i),
      .tck_lvl_i      (tck_lvl_i),
      .dbg_maskints_i (dbg_maskints_i),
      .pend_valid_o   (pend_valid),
      .pend_lvl_o     (pend_lvl),
      .pend_num_o     (pend_num)
   );

   //-----------------------------------------------------------------------
   // registered decision
   //-----------------------------------------------------------------------

   nvic_preempt u_preempt (
      .sclk           (sclk),
      .hreset_n       (hreset_n),
      .actv_bit_i     (actv_bit),
      .int_actv_i     (int_actv),
      .int_actv_lvl_i (int_actv_lvl),
      .pend_valid_i   (pend_valid),
      .pend_lvl_i     (pend_lvl),
      .pend_num_i     (pend_num),
      .svc_lvl_i      (svc_lvl_i),
      .pend_nmi_i     (pend_nmi_i),
      .pend_hdf_i     (pend_hdf_i),
      .primask_i      (primask_i),
      .int_pend_o     (int_pend_o),
      .wfi_advance_o  (wfi_advance_o),
      .svc_escalate_o (svc_escalate_o),
      .int_pend_num_o (int_pend_num_o),
      .actv_bit_o     (actv_bit_o)
   );

endmodule

//--- testbench/tb_nvic_prio.sv
//--------------------------------------------------------------------------
// NVIC priority core testbench
// random stimulus from an lfsr, checked each cycle against a model of
// the active decode, pending selection and preemption rules
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "nvic_defs.svh"

module tb_nvic_prio;

   localparam int RESET_CYC   = 16;
   localparam int RAND_CYC    = 4000;
   // margin over reset plus random cycles, 4200 in all
   localparam int TIMEOUT_CYC = RESET_CYC + RAND_CYC + 184;

   logic sclk, hreset_n, nmi_active_i, hdf_active_i, primask_i, dbg_maskints_i;
   logic pend_nmi_i, pend_hdf_i, pend_svc_i, pend_psv_i, pend_tck_i;
   nvic_pkg::vec_num_t  ipsr_i;
   nvic_pkg::irq_mask_t pend_irq_i;
   nvic_pkg::irq_mask_t irq_en_i;
   nvic_pkg::prio_lvl_t svc_lvl_i;
   nvic_pkg::prio_lvl_t psv_lvl_i;
   nvic_pkg::prio_lvl_t tck_lvl_i;
   nvic_pkg::irq_lvl_t  irq_lvl_i;
   logic int_pend_o, wfi_advance_o, svc_escalate_o;
   nvic_pkg::vec_num_t  int_pend_num_o;
   nvic_pkg::actv_bit_t actv_bit_o;

   // predictions for the next check
   logic exp_pend, exp_wfi, exp_esc;
   nvic_pkg::vec_num_t  exp_num;
   nvic_pkg::actv_bit_t exp_actv;
   int err_pend, err_num, err_wfi, err_esc, err_actv;
   int cycle_cnt;
   logic [15:0] lfsr;

   nvic_prio_top u_dut (
      .sclk (sclk), .hreset_n (hreset_n), .ipsr_i (ipsr_i),
      .nmi_active_i (nmi_active_i), .hdf_active_i (hdf_active_i),
      .primask_i (primask_i), .dbg_maskints_i (dbg_maskints_i),
      .pend_nmi_i (pend_nmi_i), .pend_hdf_i (pend_hdf_i), .pend_svc_i (pend_svc_i),
      .pend_psv_i (pend_psv_i), .pend_tck_i (pend_tck_i), .pend_irq_i (pend_irq_i),
      .irq_en_i (irq_en_i), .svc_lvl_i (svc_lvl_i), .psv_lvl_i (psv_lvl_i),
      .tck_lvl_i (tck_lvl_i), .irq_lvl_i (irq_lvl_i), .int_pend_o (int_pend_o),
      .int_pend_num_o (int_pend_num_o), .wfi_advance_o (wfi_advance_o),
      .svc_escalate_o (svc_escalate_o), .actv_bit_o (actv_bit_o)
   );

   always #10 sclk = ~sclk;

   // watchdog on the whole run
   always @(posedge sclk)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC)
      begin
         $display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
         $display("Simulation failed");
         $finish;
      end
   end

   //-----------------------------------------------------------------------
   // random source
   //-----------------------------------------------------------------------

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit drawn
   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] val;

      val = '0;
      for (int k = 0; k < n; k++)
      begin
         val  = {val[62:0], lfsr[15]};
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      end
      return val;
   endfunction

   task automatic clear_inputs();
      ipsr_i         = '0;
      nmi_active_i   = 1'b0;
      hdf_active_i   = 1'b0;
      primask_i      = 1'b0;
      dbg_maskints_i = 1'b0;
      pend_nmi_i     = 1'b0;
      pend_hdf_i     = 1'b0;
      pend_svc_i     = 1'b0;
      pend_psv_i     = 1'b0;
      pend_tck_i     = 1'b0;
      pend_irq_i     = '0;
      irq_en_i       = '0;
      svc_lvl_i      = '0;
      psv_lvl_i      = '0;
      tck_lvl_i      = '0;
      irq_lvl_i      = '0;
   endtask

   task automatic drive_random();
      logic [63:0] a;
      logic [63:0] b;

      a = lfsr_bits(1);
      b = lfsr_bits(6);
      // half the time one of the implemented numbers
      if (a[0])
      begin
         b = b % 38;
         case (b)
            0: ipsr_i = 6'd0;
            1: ipsr_i = `NVIC_VEC_NMI;
            2: ipsr_i = `NVIC_VEC_HDF;
            3: ipsr_i = `NVIC_VEC_SVC;
            4: ipsr_i = `NVIC_VEC_PSV;
            5: ipsr_i = `NVIC_VEC_TCK;
            default: ipsr_i = `NVIC_VEC_IRQ0 + b[5:0] - 6'd6;
         endcase
      end
      else
         ipsr_i = b[5:0];
      nmi_active_i   = (lfsr_bits(2) == 64'd3);
      hdf_active_i   = (lfsr_bits(2) == 64'd3);
      pend_nmi_i     = (lfsr_bits(2) == 64'd3);
      pend_hdf_i     = (lfsr_bits(2) == 64'd3);
      dbg_maskints_i = (lfsr_bits(2) == 64'd3);
      primask_i      = (lfsr_bits(1) == 64'd1);
      a = lfsr_bits(3);
      {pend_svc_i, pend_psv_i, pend_tck_i} = a[2:0];
      a = lfsr_bits(6);
      {svc_lvl_i, psv_lvl_i, tck_lvl_i} = a[5:0];
      // sparse irq pending so the levels matter
      a = lfsr_bits(32);
      b = lfsr_bits(32);
      pend_irq_i = a[31:0] & b[31:0];
      a = lfsr_bits(32);
      irq_en_i  = a[31:0];
      irq_lvl_i = lfsr_bits(64);
   endtask

   //-----------------------------------------------------------------------
   // reference model
   //-----------------------------------------------------------------------

   task automatic predict();
      logic       int_actv, n_or_h, best_v, tree_pre, nmi_pre, hdf_pre, cv;
      logic [1:0] act_lvl, best_lvl, cl;
      logic [5:0] best_num;

      exp_actv    = '0;
      exp_actv[0] = nmi_active_i;
      exp_actv[1] = hdf_active_i;
      int_actv    = 1'b1;
      act_lvl     = 2'd0;
      if (ipsr_i == `NVIC_VEC_SVC)
      begin
         exp_actv[2] = 1'b1;
         act_lvl     = svc_lvl_i;
      end
      else if (ipsr_i == `NVIC_VEC_PSV)
      begin
         exp_actv[3] = 1'b1;
         act_lvl     = psv_lvl_i;
      end
      else if (ipsr_i == `NVIC_VEC_TCK)
      begin
         exp_actv[4] = 1'b1;
         act_lvl     = tck_lvl_i;
      end
      else if (ipsr_i >= `NVIC_VEC_IRQ0 && ipsr_i < `NVIC_VEC_IRQ0 + `NVIC_NUM_IRQ)
      begin
         exp_actv[5 + ipsr_i - 16] = 1'b1;
         act_lvl = irq_lvl_i[2*(ipsr_i-16) +: 2];
      end
      else
         int_actv = 1'b0;
      // linear scan in vector order, strictly lower level replaces
      best_v   = 1'b0;
      best_lvl = 2'd0;
      best_num = 6'd0;
      for (int v = 11; v < 48; v++)
      begin
         cv = 1'b0;
         cl = 2'd0;
         if (v == 11)
         begin
            cv = pend_svc_i;
            cl = svc_lvl_i;
         end
         else if (v == 14)
         begin
            cv = pend_psv_i & ~dbg_maskints_i;
            cl = psv_lvl_i;
         end
         else if (v == 15)
         begin
            cv = pend_tck_i & ~dbg_maskints_i;
            cl = tck_lvl_i;
         end
         else if (v >= 16)
         begin
            cv = pend_irq_i[v-16] & irq_en_i[v-16] & ~dbg_maskints_i;
            cl = irq_lvl_i[2*(v-16) +: 2];
         end
         if (cv && (!best_v || cl < best_lvl))
         begin
            best_v   = 1'b1;
            best_lvl = cl;
            best_num = 6'(v);
         end
      end
      n_or_h   = nmi_active_i | hdf_active_i;
      nmi_pre  = pend_nmi_i & ~nmi_active_i;
      hdf_pre  = pend_hdf_i & ~n_or_h;
      tree_pre = best_v & (~int_actv | (best_lvl < act_lvl)) & ~n_or_h;
      exp_pend = (tree_pre & ~primask_i) | nmi_pre | hdf_pre;
      exp_wfi  = tree_pre | nmi_pre | hdf_pre;
      exp_num  = pend_nmi_i ? `NVIC_VEC_NMI : (pend_hdf_i ? `NVIC_VEC_HDF : best_num);
      exp_esc  = int_actv & (svc_lvl_i >= act_lvl);
      // outputs held at zero while in reset
      if (!hreset_n)
      begin
         exp_pend = 1'b0;
         exp_wfi  = 1'b0;
         exp_esc  = 1'b0;
         exp_num  = '0;
         exp_actv = '0;
      end
   endtask

   task automatic check_outputs();
      assert (int_pend_o === exp_pend)
      else
      begin
         err_pend++;
         $display("Error at %0t ns: int_pend_o exp %0b got %0b", $time, exp_pend, int_pend_o);
      end
      assert (int_pend_num_o === exp_num)
      else
      begin
         err_num++;
         $display("Error at %0t ns: int_pend_num_o exp %0d got %0d", $time, exp_num,
                  int_pend_num_o);
      end
      assert (wfi_advance_o === exp_wfi)
      else
      begin
         err_wfi++;
         $display("Error at %0t ns: wfi_advance_o exp %0b got %0b", $time, exp_wfi,
                  wfi_advance_o);
      end
      assert (svc_escalate_o === exp_esc)
      else
      begin
         err_esc++;
         $display("Error at %0t ns: svc_escalate_o exp %0b got %0b", $time, exp_esc,
                  svc_escalate_o);
      end
      assert (actv_bit_o === exp_actv)
      else
      begin
         err_actv++;
         $display("Error at %0t ns: actv_bit_o exp %h got %h", $time, exp_actv, actv_bit_o);
      end
   endtask

   //-----------------------------------------------------------------------
   // main sequence
   //-----------------------------------------------------------------------

   initial
   begin
      sclk      = 1'b0;
      hreset_n  = 1'b0;
      lfsr      = 16'd29;
      cycle_cnt = 0;
      err_pend  = 0;
      err_num   = 0;
      err_wfi   = 0;
      err_esc   = 0;
      err_actv  = 0;
      clear_inputs();
      predict();
      // random inputs during reset must not reach the outputs
      // inputs return to zero for the first cycle after reset
      for (int c = 0; c < RESET_CYC + 1 + RAND_CYC; c++)
      begin
         @(negedge sclk);
         check_outputs();
         if (c == RESET_CYC)
         begin
            hreset_n = 1'b1;
            clear_inputs();
         end
         else
            drive_random();
         predict();
      end
      @(negedge sclk);
      check_outputs();
      $display("errors: int_pend_o %0d, int_pend_num_o %0d, wfi_advance_o %0d, %s %0d, %s %0d",
               err_pend, err_num, err_wfi, "svc_escalate_o", err_esc, "actv_bit_o", err_actv);
      if (err_pend + err_num + err_wfi + err_esc + err_actv == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- sources.f
+incdir+source
source/nvic_pkg.sv
source/nvic_active_decode.sv
source/nvic_pend_tree.sv
source/nvic_preempt.sv
source/nvic_prio_top.sv
testbench/tb_nvic_prio.sv
